// File: src/aznable_pkg.sv
package aznable_pkg;

	// Raster geometry in pixels and lines
	localparam int COUNT_W = 9;
	localparam int PIXEL_DIV = 4;
	localparam int DIV_W = $clog2(PIXEL_DIV);
	localparam logic [COUNT_W-1:0] H_VISIBLE = 9'd320;
	localparam logic [COUNT_W-1:0] H_TOTAL = 9'd384;
	localparam logic [COUNT_W-1:0] HS_START = 9'd336;
	localparam logic [COUNT_W-1:0] HS_END = 9'd368;
	localparam logic [COUNT_W-1:0] V_VISIBLE = 9'd240;
	localparam logic [COUNT_W-1:0] V_TOTAL = 9'd262;
	localparam logic [COUNT_W-1:0] VS_START = 9'd244;
	localparam logic [COUNT_W-1:0] VS_END = 9'd247;

	// System bus
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Memory map
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 16'h8000;
	localparam logic [ADDR_W-1:0] ADDR_TIMER = 16'h80C0;
	localparam logic [ADDR_W-1:0] ADDR_JOY = 16'h8100;
	localparam logic [ADDR_W-1:0] ADDR_STAR = 16'h8500;
	localparam logic [ADDR_W-1:0] ADDR_PAUSE = 16'h8530;
	localparam logic [ADDR_W-1:0] ADDR_MENU = 16'h8531;
	localparam int JOY_BYTES = 24;
	localparam int JOY_IDX_W = $clog2(JOY_BYTES);
	localparam int STAR_STRIDE = 'h10;

	// Millisecond timer at 24 MHz
	localparam int MS_PRESCALE = 24000;
	localparam int PRESCALE_W = $clog2(MS_PRESCALE);
	localparam int TIMER_W = 16;

	// Starfield layers, index 0 has the highest priority
	localparam int STAR_LAYERS = 3;
	localparam int LFSR_W = 22;
	localparam logic [LFSR_W-1:0] STAR_SEED [STAR_LAYERS] = '{
		22'h1FFFFF, 22'h1FFFF0, 22'h1FFF00
	};
	localparam logic [LFSR_W-1:0] STAR_TAPS [STAR_LAYERS] = '{
		22'h300000, 22'h150000, 22'h140000
	};
	// A star shows where every masked bit is set
	localparam logic [LFSR_W-1:0] STAR_MASK [STAR_LAYERS] = '{
		22'h03C3C3, 22'h01E1E1, 22'h01E1E1
	};
	localparam logic [7:0] STAR_CAP [STAR_LAYERS] = '{8'hFF, 8'h7F, 8'h3F};

endpackage

// File: src/video_timing.sv
`timescale 1ns/100ps

module video_timing (
	input logic clk_24,
	input logic rst_n,
	output logic pix_en,
	output logic [aznable_pkg::COUNT_W-1:0] hcnt,
	output logic [aznable_pkg::COUNT_W-1:0] vcnt,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync
);
	import aznable_pkg::*;

	logic [DIV_W-1:0] div_cnt;
	logic line_end;

	// One pixel every PIXEL_DIV clocks
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
		end
		else if (pix_en)
		begin
			div_cnt <= '0;
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign pix_en = div_cnt == DIV_W'(PIXEL_DIV - 1);
	assign line_end = hcnt == H_TOTAL - 1'b1;

	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hcnt <= '0;
			vcnt <= '0;
		end
		else if (pix_en)
		begin
			if (line_end)
			begin
				hcnt <= '0;
				// Wrap to the top line after the last one
				if (vcnt == V_TOTAL - 1'b1)
				begin
					vcnt <= '0;
				end
				else
				begin
					vcnt <= vcnt + 1'b1;
				end
			end
			else
			begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// Blanking and active high sync from the counters
	assign hblank = hcnt >= H_VISIBLE;
	assign vblank = vcnt >= V_VISIBLE;
	assign hsync = (hcnt >= HS_START) && (hcnt < HS_END);
	assign vsync = (vcnt >= VS_START) && (vcnt < VS_END);

endmodule

// File: src/system_regs.sv
`timescale 1ns/100ps

module system_regs (
	input logic clk_24,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [aznable_pkg::ADDR_W-1:0] wb_adr,
	input logic [aznable_pkg::DATA_W-1:0] wb_dat_w,
	output logic [aznable_pkg::DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	input logic pause,
	input logic menu,
	input logic [8*aznable_pkg::JOY_BYTES-1:0] joystick,
	input logic hsync,
	input logic vsync,
	input logic hblank,
	input logic vblank,
	output logic system_pause,
	output logic star_wr,
	output logic [1:0] star_layer,
	output logic [aznable_pkg::DATA_W-1:0] star_data
);
	import aznable_pkg::*;

	logic bus_req;
	logic bus_wr;
	logic status_cs;
	logic timer_cs;
	logic joy_cs;
	logic star_cs;
	logic pause_cs;
	logic menu_cs;
	logic [ADDR_W-1:0] joy_off;
	logic [ADDR_W-1:0] star_off;
	logic [ADDR_W-1:0] star_idx;
	logic [DATA_W-1:0] rd_data;
	logic [PRESCALE_W-1:0] prescale;
	logic [TIMER_W-1:0] ms_timer;
	logic pause_trig;
	logic menu_trig;

	// A new request; the ack cycle itself is never taken as one
	assign bus_req = wb_cyc & wb_stb & ~wb_ack;
	assign bus_wr = bus_req & wb_we;

	// Address decode, offsets wrap so one compare covers each window
	assign joy_off = wb_adr - ADDR_JOY;
	assign star_off = wb_adr - ADDR_STAR;
	assign star_idx = star_off / ADDR_W'(STAR_STRIDE);
	assign status_cs = wb_adr == ADDR_STATUS;
	assign timer_cs = (wb_adr == ADDR_TIMER) || (wb_adr == ADDR_TIMER + 1'b1);
	assign joy_cs = joy_off < ADDR_W'(JOY_BYTES);
	assign star_cs = star_off < ADDR_W'(STAR_LAYERS * STAR_STRIDE);
	assign pause_cs = wb_adr == ADDR_PAUSE;
	assign menu_cs = wb_adr == ADDR_MENU;

	always_comb
	begin
		rd_data = '0;
		if (status_cs)
			rd_data = {hsync, vsync, hblank, vblank, 2'b10, menu, 1'b0};
		else if (timer_cs)
			rd_data = wb_adr[0] ? ms_timer[DATA_W +: DATA_W] : ms_timer[0 +: DATA_W];
		else if (joy_cs)
			rd_data = joystick[{joy_off[JOY_IDX_W-1:0], 3'b000} +: DATA_W];
		else if (menu_cs)
			rd_data = {DATA_W{menu_trig}};
	end

	// Single cycle ack, one clock after the request is seen
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= bus_req;
	end

	always_ff @(posedge clk_24)
	begin
		if (bus_req)
			wb_dat_r <= rd_data;
	end

	// Millisecond timer, restarted by a write to either byte
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prescale <= '0;
			ms_timer <= '0;
		end
		else if (bus_wr && timer_cs)
		begin
			prescale <= '0;
			ms_timer <= '0;
		end
		else if (prescale == PRESCALE_W'(MS_PRESCALE - 1))
		begin
			prescale <= '0;
			ms_timer <= ms_timer + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	// Pause input wins over a write; a write wins over the menu input
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pause_trig <= 1'b0;
			menu_trig <= 1'b0;
		end
		else
		begin
			if (pause)
				pause_trig <= 1'b0;
			else if (bus_wr && pause_cs)
				pause_trig <= 1'b1;
			if (bus_wr && menu_cs)
				menu_trig <= 1'b0;
			else if (menu)
				menu_trig <= 1'b1;
		end
	end

	assign system_pause = pause | pause_trig;

	assign star_wr = bus_wr & star_cs;
	assign star_layer = star_idx[1:0];
	assign star_data = wb_dat_w;

endmodule

// File: src/starfield_config.sv
`timescale 1ns/100ps

module starfield_config (
	input logic clk_24,
	input logic rst_n,
	input logic star_wr,
	input logic [1:0] star_layer,
	input logic [aznable_pkg::DATA_W-1:0] star_data,
	input logic pix_en,
	input logic hblank,
	input logic vblank,
	input logic system_pause,
	output logic [aznable_pkg::STAR_LAYERS-1:0] layer_en,
	output logic restart,
	output logic advance
);
	import aznable_pkg::*;

	logic vblank_q;

	// Bit 0 of any byte in a layer window enables that layer
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			layer_en <= '0;
		end
		else
		begin
			for (int i = 0; i < STAR_LAYERS; i++)
			begin
				if (star_wr && star_layer == 2'(i))
					layer_en[i] <= star_data[0];
			end
		end
	end

	// Reseed all layers once per frame at the start of vblank
	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vblank_q <= 1'b0;
			restart <= 1'b0;
		end
		else
		begin
			vblank_q <= vblank;
			restart <= vblank & ~vblank_q;
		end
	end

	// Step only on visible pixels, and freeze while paused
	assign advance = pix_en & ~hblank & ~vblank & ~system_pause;

endmodule

// File: src/starfield_layer.sv
`timescale 1ns/100ps

module starfield_layer #(
	parameter int LAYER = 0
) (
	input logic clk_24,
	input logic rst_n,
	input logic enable,
	input logic restart,
	input logic advance,
	output logic star_on,
	output logic [7:0] star_bright
);
	import aznable_pkg::*;

	logic [LFSR_W-1:0] lfsr;
	logic feedback;
	logic star_hit;

	// Fibonacci feedback from the tapped bits
	assign feedback = ^(lfsr & STAR_TAPS[LAYER]);
	assign star_hit = (lfsr & STAR_MASK[LAYER]) == STAR_MASK[LAYER];

	always_ff @(posedge clk_24 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lfsr <= '0;
			star_on <= 1'b0;
			star_bright <= '0;
		end
		else if (restart)
		begin
			// Same seed every frame keeps the field in place
			lfsr <= STAR_SEED[LAYER];
			star_on <= 1'b0;
		end
		else if (advance)
		begin
			lfsr <= {lfsr[LFSR_W-2:0], feedback};
			star_on <= enable & star_hit;
			star_bright <= lfsr[7:0];
		end
	end

endmodule

// File: src/layer_mixer.sv
`timescale 1ns/100ps

module layer_mixer (
	input logic [aznable_pkg::STAR_LAYERS-1:0] star_on,
	input logic [aznable_pkg::STAR_LAYERS*8-1:0] star_bright,
	input logic hblank,
	input logic vblank,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import aznable_pkg::*;

	logic [7:0] grey;

	always_comb
	begin
		grey = '0;
		// Walk from the back so the lowest layer with a star wins
		for (int i = STAR_LAYERS - 1; i >= 0; i--)
		begin
			if (star_on[i])
				grey = star_bright[i*8 +: 8] & STAR_CAP[i];
		end
		if (hblank || vblank)
			grey = '0;
	end

	// Stars are white, so all channels carry the same level
	assign vga_r = grey;
	assign vga_g = grey;
	assign vga_b = grey;

endmodule

// File: src/aznable_top.sv
`timescale 1ns/100ps

module aznable_top (
	input logic clk_24,
	input logic rst_n,
	input logic pause,
	input logic menu,
	input logic [8*aznable_pkg::JOY_BYTES-1:0] joystick,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [aznable_pkg::ADDR_W-1:0] wb_adr,
	input logic [aznable_pkg::DATA_W-1:0] wb_dat_w,
	output logic [aznable_pkg::DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic system_pause,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_hb,
	output logic vga_vb,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);
	import aznable_pkg::*;

	logic pix_en;
	logic star_wr;
	logic [1:0] star_layer;
	logic [DATA_W-1:0] star_data;
	logic [STAR_LAYERS-1:0] layer_en;
	logic restart;
	logic advance;
	logic [STAR_LAYERS-1:0] star_on;
	logic [STAR_LAYERS*8-1:0] star_bright;

	// Counters stay inside, only the flags leave the timer
	video_timing i_timing (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.pix_en(pix_en),
		.hcnt(),
		.vcnt(),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.hsync(vga_hs),
		.vsync(vga_vs)
	);

	system_regs i_regs (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.pause(pause),
		.menu(menu),
		.joystick(joystick),
		.hsync(vga_hs),
		.vsync(vga_vs),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.system_pause(system_pause),
		.star_wr(star_wr),
		.star_layer(star_layer),
		.star_data(star_data)
	);

	starfield_config i_config (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.star_wr(star_wr),
		.star_layer(star_layer),
		.star_data(star_data),
		.pix_en(pix_en),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.system_pause(system_pause),
		.layer_en(layer_en),
		.restart(restart),
		.advance(advance)
	);

	for (genvar g = 0; g < STAR_LAYERS; g++)
	begin : g_layer
		starfield_layer #(
			.LAYER(g)
		) i_layer (
			.clk_24(clk_24),
			.rst_n(rst_n),
			.enable(layer_en[g]),
			.restart(restart),
			.advance(advance),
			.star_on(star_on[g]),
			.star_bright(star_bright[g*8 +: 8])
		);
	end

	layer_mixer i_mixer (
		.star_on(star_on),
		.star_bright(star_bright),
		.hblank(vga_hb),
		.vblank(vga_vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

// File: verification/tb_aznable.sv
`timescale 1ns/100ps

module tb_aznable;
	import aznable_pkg::*;

	localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL) * PIXEL_DIV;
	// Four frames of starfield phases plus the bus and timer work
	localparam int WATCHDOG_CYCLES = 4 * FRAME_CYCLES + 30000;
	localparam int ACK_LIMIT = 16;
	localparam int HS_CLOCKS = int'(HS_END - HS_START) * PIXEL_DIV;
	localparam int VS_CLOCKS = int'(VS_END - VS_START) * int'(H_TOTAL) * PIXEL_DIV;

	logic clk_24 = 1'b0;
	logic rst_n;
	logic pause;
	logic menu;
	logic [8*JOY_BYTES-1:0] joystick;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_dat_w;
	logic [DATA_W-1:0] wb_dat_r;
	logic wb_ack;
	logic system_pause;
	logic vga_hs;
	logic vga_vs;
	logic vga_hb;
	logic vga_vb;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	int errors = 0;
	int transfers = 0;
	int frames = 0;
	int hb_rises = 0;
	int hs_rises = 0;
	int vs_rises = 0;
	int hs_len = 0;
	int vs_len = 0;
	int lit_count = 0;
	int seed = 66687;
	bit raster_armed = 1'b0;
	bit dark_mode = 1'b1;
	bit l2_mode = 1'b0;
	bit all_mode = 1'b0;
	logic vb_q;
	logic hb_q;
	logic hs_q;
	logic vs_q;

	aznable_top i_dut (
		.clk_24(clk_24),
		.rst_n(rst_n),
		.pause(pause),
		.menu(menu),
		.joystick(joystick),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.system_pause(system_pause),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_hb(vga_hb),
		.vga_vb(vga_vb),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	always #5 clk_24 = ~clk_24;

	// Bus handshake
	a_reset_ack: assert property (@(posedge clk_24) !rst_n |=> !wb_ack)
	else
	begin
		errors++;
		$display("[ERROR] wb_ack expected 0 got %h", $sampled(wb_ack));
	end

	a_ack_follows_req: assert property (@(posedge clk_24) disable iff (!rst_n)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
	else
	begin
		errors++;
		$display("[ERROR] wb_ack expected 1 got %h", $sampled(wb_ack));
	end

	a_ack_single: assert property (@(posedge clk_24) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
	else
	begin
		errors++;
		$display("[ERROR] wb_ack expected 0 got %h", $sampled(wb_ack));
	end

	a_ack_needs_req: assert property (@(posedge clk_24) disable iff (!rst_n)
		!(wb_cyc && wb_stb) |=> !wb_ack)
	else
	begin
		errors++;
		$display("[ERROR] wb_ack expected 0 got %h", $sampled(wb_ack));
	end

	// Video output
	a_blank_black: assert property (@(posedge clk_24) disable iff (!rst_n)
		(vga_hb || vga_vb) |-> (vga_r == 8'h00 && vga_g == 8'h00 && vga_b == 8'h00))
	else
	begin
		errors++;
		$display("[ERROR] vga_r expected 00 got %h", $sampled(vga_r));
	end

	a_hsync_in_blank: assert property (@(posedge clk_24) disable iff (!rst_n)
		vga_hs |-> vga_hb)
	else
	begin
		errors++;
		$display("[ERROR] vga_hb expected 1 got %h", $sampled(vga_hb));
	end

	a_vsync_in_blank: assert property (@(posedge clk_24) disable iff (!rst_n)
		vga_vs |-> vga_vb)
	else
	begin
		errors++;
		$display("[ERROR] vga_vb expected 1 got %h", $sampled(vga_vb));
	end

	a_grey: assert property (@(posedge clk_24) disable iff (!rst_n)
		(vga_r == vga_g) && (vga_g == vga_b))
	else
	begin
		errors++;
		$display("[ERROR] vga_g expected %h got %h", $sampled(vga_r), $sampled(vga_g));
	end

	a_dark: assert property (@(posedge clk_24) disable iff (!rst_n)
		dark_mode |-> vga_r == 8'h00)
	else
	begin
		errors++;
		$display("[ERROR] vga_r expected 00 got %h", $sampled(vga_r));
	end

	a_layer2_cap: assert property (@(posedge clk_24) disable iff (!rst_n)
		l2_mode |-> vga_r <= 8'h3F)
	else
	begin
		errors++;
		$display("[ERROR] vga_r expected <= 3f got %h", $sampled(vga_r));
	end

	a_pause_release: assert property (@(posedge clk_24) disable iff (!rst_n)
		$fell(pause) |-> !system_pause)
	else
	begin
		errors++;
		$display("[ERROR] system_pause expected 0 got %h", $sampled(system_pause));
	end

	// Per frame counts of lines, syncs and lit pixels
	always @(posedge clk_24)
	begin
		if (!rst_n)
		begin
			vb_q <= 1'b0;
			hb_q <= 1'b0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
		end
		else
		begin
			vb_q <= vga_vb;
			hb_q <= vga_hb;
			hs_q <= vga_hs;
			vs_q <= vga_vs;
			if (vga_vb && !vb_q)
			begin
				if (raster_armed)
				begin
					assert (hb_rises == int'(V_TOTAL))
					else
					begin
						errors++;
						$display("[ERROR] hblank rises expected %h got %h", V_TOTAL, hb_rises);
					end
					assert (hs_rises == int'(V_TOTAL))
					else
					begin
						errors++;
						$display("[ERROR] vga_hs rises expected %h got %h", V_TOTAL, hs_rises);
					end
					assert (vs_rises == 1)
					else
					begin
						errors++;
						$display("[ERROR] vga_vs rises expected 1 got %h", vs_rises);
					end
				end
				if (all_mode || l2_mode)
				begin
					assert (lit_count > 0)
					else
					begin
						errors++;
						$display("No lit pixel in a frame with star layers enabled");
					end
				end
				raster_armed <= 1'b1;
				hb_rises <= 0;
				hs_rises <= 0;
				vs_rises <= 0;
				lit_count <= 0;
				frames <= frames + 1;
			end
			else
			begin
				if (vga_hb && !hb_q)
					hb_rises <= hb_rises + 1;
				if (vga_hs && !hs_q)
					hs_rises <= hs_rises + 1;
				if (vga_vs && !vs_q)
					vs_rises <= vs_rises + 1;
				if (!vga_hb && !vga_vb && vga_r != 8'h00)
					lit_count <= lit_count + 1;
			end
			// Sync pulse widths in clocks
			if (vga_hs)
				hs_len <= hs_len + 1;
			else if (hs_q)
			begin
				assert (hs_len == HS_CLOCKS)
				else
				begin
					errors++;
					$display("[ERROR] vga_hs width expected %h got %h", HS_CLOCKS, hs_len);
				end
				hs_len <= 0;
			end
			if (vga_vs)
				vs_len <= vs_len + 1;
			else if (vs_q)
			begin
				assert (vs_len == VS_CLOCKS)
				else
				begin
					errors++;
					$display("[ERROR] vga_vs width expected %h got %h", VS_CLOCKS, vs_len);
				end
				vs_len <= 0;
			end
		end
	end

	task automatic expect_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("[ERROR] %s expected %h got %h", name, expected, actual);
		end
	endtask

	// One classic cycle, held through the clock edge where ack is sampled
	task automatic transfer(input bit we, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk_24);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = addr;
		wb_dat_w = wdata;
		do
		begin
			@(negedge clk_24);
			waited++;
		end
		while (!wb_ack && waited < ACK_LIMIT);
		if (!wb_ack)
		begin
			errors++;
			$display("No ack from the bus slave at address %h", addr);
		end
		rdata = wb_dat_r;
		@(negedge clk_24);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		transfers++;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		transfer(1'b0, addr, 8'h00, data);
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused;
		transfer(1'b1, addr, data, unused);
	endtask

	task automatic wait_frame_count(input int count);
		while (frames < count)
			@(negedge clk_24);
	endtask

	initial
	begin
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] timer_lo;
		logic [DATA_W-1:0] timer_hi;
		rst_n = 1'b0;
		pause = 1'b0;
		menu = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		for (int i = 0; i < 8 * JOY_BYTES / 32; i++)
			joystick[32*i +: 32] = $random(seed);
		repeat (2) @(negedge clk_24);
		rst_n = 1'b1;
		expect_value("wb_ack", 16'h0000, 16'(wb_ack));

		// Unmapped space and the status byte
		read_reg(16'h4000, data);
		expect_value("wb_dat_r", 16'h0000, 16'(data));
		write_reg(16'h4000, 8'h5A);
		read_reg(16'h4000, data);
		expect_value("wb_dat_r", 16'h0000, 16'(data));
		read_reg(ADDR_STATUS, data);
		expect_value("status[3:0]", 16'h0008, 16'(data[3:0]));

		for (int n = 0; n < JOY_BYTES; n++)
		begin
			read_reg(ADDR_JOY + ADDR_W'(n), data);
			expect_value("joystick byte", 16'(joystick[8*n +: 8]), 16'(data));
		end

		// Menu trigger is set by the input and cleared by a write
		@(negedge clk_24);
		menu = 1'b1;
		@(negedge clk_24);
		menu = 1'b0;
		read_reg(ADDR_MENU, data);
		expect_value("menu", 16'h00FF, 16'(data));
		write_reg(ADDR_MENU, 8'h00);
		read_reg(ADDR_MENU, data);
		expect_value("menu", 16'h0000, 16'(data));

		// Let the timer count past one millisecond before clearing it
		repeat (MS_PRESCALE + 100) @(negedge clk_24);
		write_reg(ADDR_TIMER, 8'h00);
		read_reg(ADDR_TIMER, timer_lo);
		read_reg(ADDR_TIMER + 16'd1, timer_hi);
		expect_value("ms_timer", 16'h0000, {timer_hi, timer_lo});
		repeat (MS_PRESCALE + 100) @(negedge clk_24);
		read_reg(ADDR_TIMER, timer_lo);
		read_reg(ADDR_TIMER + 16'd1, timer_hi);
		assert ({timer_hi, timer_lo} >= 16'h0001)
		else
		begin
			errors++;
			$display("[ERROR] ms_timer expected >= 0001 got %h", {timer_hi, timer_lo});
		end

		write_reg(ADDR_PAUSE, 8'h01);
		expect_value("system_pause", 16'h0001, 16'(system_pause));
		pause = 1'b1;
		@(negedge clk_24);
		pause = 1'b0;
		@(negedge clk_24);
		expect_value("system_pause", 16'h0000, 16'(system_pause));

		// A whole dark frame first, then layer 2 alone and then every layer
		wait_frame_count(2);
		dark_mode = 1'b0;
		write_reg(ADDR_STAR + ADDR_W'(2 * STAR_STRIDE), 8'h01);
		l2_mode = 1'b1;
		wait_frame_count(3);
		l2_mode = 1'b0;
		write_reg(ADDR_STAR, 8'h01);
		write_reg(ADDR_STAR + ADDR_W'(STAR_STRIDE), 8'h01);
		all_mode = 1'b1;
		wait_frame_count(4);
		all_mode = 1'b0;

		@(negedge clk_24);
		$display("Errors: %0d, bus transfers: %0d, frames: %0d", errors, transfers, frames);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_24);
		$display("Watchdog timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Errors: %0d, bus transfers: %0d, frames: %0d", errors, transfers, frames);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: project.f
src/aznable_pkg.sv
src/video_timing.sv
src/system_regs.sv
src/starfield_config.sv
src/starfield_layer.sv
src/layer_mixer.sv
src/aznable_top.sv
verification/tb_aznable.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert \
	--top-module tb_aznable \
	-f project.f \
	-Mdir obj_dir \
	-o sim_aznable

./obj_dir/sim_aznable | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
